//--- rtl/sta_pkg.sv
`default_nettype none

package sta_pkg;

  // Array is fixed at 2x2 since the readout and pooling are built around one 2x2 window
  localparam int SA_N = 2;

  typedef logic signed [31:0] acc_t;    // Accumulator value
  typedef logic signed [7:0]  pix_t;    // int8 operand or pixel
  typedef logic        [7:0]  klen_t;   // Reduction steps per tile, never zero
  typedef logic signed [15:0] scale_t;  // Requantization multiplier
  typedef logic        [4:0]  shift_t;  // Arithmetic right shift amount

  // One int8 lane per array row (A) or array column (B)
  typedef pix_t [SA_N-1:0] vec_t;

  typedef enum logic [2:0] {
    IDLE,   // Waiting for tile_req
    FEED,   // Operands streaming in
    DRAIN,  // Last operands crossing the grid
    READ,   // Reader walking the accumulators
    FLUSH,  // Last beats leaving requantizer and pool
    DONE    // tile_ack high until tile_req drops
  } tile_state_t;

  // Corner cell sees its last operand 2*(SA_N-1) edges late, plus one for the operand register
  localparam klen_t DRAIN_CYCLES = klen_t'(2*(SA_N-1)+1);
  localparam klen_t FLUSH_CYCLES = klen_t'(2);  // Requantizer stage + pool stage

endpackage

`default_nettype wire

//--- rtl/pix_stream_if.sv
`timescale 1ns/10ps
`default_nettype none

// Valid-only beat with output-map coordinates, no ready path
interface pix_stream_if #(
  parameter int MAX_N = 512
  ,parameter type T   = logic
);

  localparam int CW = $clog2(MAX_N+1);  // Coordinate width

  logic          valid;  // Beat taken on every clock where high
  T              data;
  logic [CW-1:0] row;    // Output map row
  logic [CW-1:0] col;    // Output map column

  modport src (output valid, output data, output row, output col);
  modport snk (input  valid, input  data, input  row, input  col);

endinterface

`default_nettype wire

//--- rtl/systolic_array.sv
`timescale 1ns/10ps
`default_nettype none

module systolic_array (
  input  logic          clk
  ,input  logic          rst_n
  ,input  logic          clear   // Zero accumulators and valid pipeline
  ,input  logic          feed    // a_vec/b_vec consumed on this edge
  ,input  sta_pkg::vec_t a_vec   // Lane i enters row i
  ,input  sta_pkg::vec_t b_vec   // Lane j enters column j
  ,output sta_pkg::acc_t acc [sta_pkg::SA_N][sta_pkg::SA_N]
);

  import sta_pkg::*;

  // Operands after input skew, one per row (A) or column (B)
  pix_t a_edge [SA_N];
  pix_t b_edge [SA_N];
  logic v_edge [SA_N];   // Valid follows the A operand

  // Cell inputs, taken from the skew edge or the west/north neighbour
  pix_t a_in [SA_N][SA_N];
  pix_t b_in [SA_N][SA_N];
  logic v_in [SA_N][SA_N];

  // Cell operand and valid registers
  pix_t a_reg [SA_N][SA_N];
  pix_t b_reg [SA_N][SA_N];
  logic v_reg [SA_N][SA_N];

  for (genvar i = 0; i < SA_N; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign a_edge[i] = a_vec[i];  // Lane 0 needs no delay
      assign b_edge[i] = b_vec[i];
      assign v_edge[i] = feed;
    end else begin : g_delay
      pix_t a_dly [i];   // Lane i waits i cycles
      pix_t b_dly [i];
      logic v_dly [i];

      always_ff @(posedge clk) begin
        a_dly[0] <= a_vec[i];
        b_dly[0] <= b_vec[i];
        for (int k = 1; k < i; k++) begin
          a_dly[k] <= a_dly[k-1];
          b_dly[k] <= b_dly[k-1];
        end
      end

      always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
          for (int k = 0; k < i; k++) v_dly[k] <= 1'b0;
        end else begin
          v_dly[0] <= feed;
          for (int k = 1; k < i; k++) v_dly[k] <= v_dly[k-1];
        end
      end

      assign a_edge[i] = a_dly[i-1];
      assign b_edge[i] = b_dly[i-1];
      assign v_edge[i] = v_dly[i-1];
    end
  end

  for (genvar i = 0; i < SA_N; i++) begin : g_row
    for (genvar j = 0; j < SA_N; j++) begin : g_col
      if (j == 0) begin : g_west
        assign a_in[i][j] = a_edge[i];
        assign v_in[i][j] = v_edge[i];
      end else begin : g_east
        assign a_in[i][j] = a_reg[i][j-1];  // A moves right
        assign v_in[i][j] = v_reg[i][j-1];
      end
      if (i == 0) begin : g_north
        assign b_in[i][j] = b_edge[j];
      end else begin : g_south
        assign b_in[i][j] = b_reg[i-1][j];  // B moves down
      end
    end
  end

  // Operands land in cell (i,j) i+j edges after the feed edge
  always_ff @(posedge clk) begin
    for (int i = 0; i < SA_N; i++) begin
      for (int j = 0; j < SA_N; j++) begin
        a_reg[i][j] <= a_in[i][j];
        b_reg[i][j] <= b_in[i][j];
        if (clear) begin
          acc[i][j] <= '0;
        end else if (v_reg[i][j]) begin
          acc[i][j] <= acc[i][j] + a_reg[i][j] * b_reg[i][j];  // Signed MAC at 32 bits
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < SA_N; i++) begin
      for (int j = 0; j < SA_N; j++) begin
        if (!rst_n || clear) v_reg[i][j] <= 1'b0;
        else                 v_reg[i][j] <= v_in[i][j];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/cycle_timer.sv
`timescale 1ns/10ps
`default_nettype none

module cycle_timer (
  input  logic           clk
  ,input  logic           rst_n
  ,input  logic           load     // Start a wait of count cycles
  ,input  sta_pkg::klen_t count    // Wait length, at least 1
  ,output logic           expired  // Last cycle of the wait and after
);

  import sta_pkg::*;

  klen_t remain;  // Cycles left after the current one

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      remain <= '0;
    end else if (load) begin
      remain <= count - klen_t'(1);   // Load cycle counts as the first
    end else if (remain != '0) begin
      remain <= remain - klen_t'(1);
    end
  end

  assign expired = (remain == '0);  // Holds at zero until reloaded

endmodule

`default_nettype wire

//--- rtl/tile_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module tile_fsm (
  input  logic           clk
  ,input  logic           rst_n
  ,input  logic           tile_req
  ,input  sta_pkg::klen_t k_len
  ,input  logic           timer_expired
  ,input  logic           read_done      // Last reader beat
  ,output logic           tile_ack
  ,output logic           idle
  ,output logic           feed_ready
  ,output logic           clear          // Accumulator clear on acceptance
  ,output logic           timer_load
  ,output sta_pkg::klen_t timer_count
  ,output logic           read_start
  ,output logic           capture        // Latch tile settings on acceptance
);

  import sta_pkg::*;

  tile_state_t state;
  tile_state_t state_nxt;
  logic        accept;   // Edge 0 of a tile

  always_ff @(posedge clk) begin
    if (!rst_n) state <= IDLE;
    else        state <= state_nxt;
  end

  assign accept = (state == IDLE) && tile_req;

  // Timer is reloaded on entry to FEED, DRAIN and FLUSH
  always_comb begin
    state_nxt   = state;
    timer_load  = 1'b0;
    timer_count = k_len;
    read_start  = 1'b0;
    case (state)
      IDLE: begin
        if (tile_req) begin
          state_nxt  = FEED;
          timer_load = 1'b1;  // k_len feed cycles
        end
      end
      FEED: begin
        if (timer_expired) begin
          state_nxt   = DRAIN;
          timer_load  = 1'b1;
          timer_count = DRAIN_CYCLES;
        end
      end
      DRAIN: begin
        if (timer_expired) begin
          state_nxt  = READ;
          read_start = 1'b1;  // All accumulators final from the next cycle
        end
      end
      READ: begin
        if (read_done) begin
          state_nxt   = FLUSH;
          timer_load  = 1'b1;
          timer_count = FLUSH_CYCLES;
        end
      end
      FLUSH: begin
        if (timer_expired) state_nxt = DONE;
      end
      DONE: begin
        if (!tile_req) state_nxt = IDLE;  // Four-phase return
      end
      default: state_nxt = IDLE;
    endcase
  end

  assign clear      = accept;
  assign capture    = accept;
  assign feed_ready = (state == FEED);
  assign tile_ack   = (state == DONE);
  assign idle       = (state == IDLE);

endmodule

`default_nettype wire

//--- rtl/result_reader.sv
`timescale 1ns/10ps
`default_nettype none

module result_reader #(
  parameter int MAX_N = 512
)(
  input  logic                       clk
  ,input  logic                       rst_n
  ,input  logic                       read_start
  ,input  sta_pkg::acc_t              acc [sta_pkg::SA_N][sta_pkg::SA_N]
  ,input  logic [$clog2(MAX_N+1)-1:0] pos_row   // Tile origin
  ,input  logic [$clog2(MAX_N+1)-1:0] pos_col
  ,output logic                       read_done // With the last beat
  ,pix_stream_if.src                  out       // int32 beats
);

  import sta_pkg::*;

  localparam int         CW   = $clog2(MAX_N+1);
  localparam logic [1:0] LAST = 2'(SA_N*SA_N-1);  // Index of cell (1,1)

  logic       active;  // Walk in progress past beat 0
  logic [1:0] idx;     // Next cell, row in bit 1
  logic       fire;    // Beat issued this edge
  logic [1:0] cur;     // Cell issued this edge

  assign fire = read_start || active;
  assign cur  = read_start ? 2'd0 : idx;  // Start always at (0,0)

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active    <= 1'b0;
      idx       <= '0;
      out.valid <= 1'b0;
      read_done <= 1'b0;
    end else begin
      out.valid <= fire;
      read_done <= fire && (cur == LAST);
      if (fire) begin
        idx    <= cur + 2'd1;
        active <= (cur != LAST);
      end
    end
  end

  // Row-major walk, coordinates offset from the tile origin
  always_ff @(posedge clk) begin
    if (fire) begin
      out.data <= acc[cur[1]][cur[0]];
      out.row  <= pos_row + CW'(cur[1]);
      out.col  <= pos_col + CW'(cur[0]);
    end
  end

endmodule

`default_nettype wire

//--- rtl/requantizer.sv
`timescale 1ns/10ps
`default_nettype none

module requantizer (
  input  logic            clk
  ,input  logic            rst_n
  ,input  sta_pkg::scale_t scale
  ,input  sta_pkg::shift_t shift
  ,pix_stream_if.snk       in    // int32 sums
  ,pix_stream_if.src       out   // int8 pixels
);

  import sta_pkg::*;

  localparam logic signed [47:0] PIX_MAX = 48'sd127;
  localparam logic signed [47:0] PIX_MIN = -48'sd128;

  logic signed [47:0] prod;     // 32x16 product never overflows
  logic signed [47:0] shifted;
  pix_t               sat;

  always_comb begin
    prod    = $signed(in.data) * scale;  // Both operands sign-extended to 48 bits
    shifted = prod >>> shift;            // Floor division by 2^shift
    if (shifted > PIX_MAX) begin
      sat = pix_t'(PIX_MAX);
    end else if (shifted < PIX_MIN) begin
      sat = pix_t'(PIX_MIN);
    end else begin
      sat = pix_t'(shifted[7:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) out.valid <= 1'b0;
    else        out.valid <= in.valid;
  end

  always_ff @(posedge clk) begin
    if (in.valid) begin
      out.data <= sat;
      out.row  <= in.row;   // Coordinates ride along unchanged
      out.col  <= in.col;
    end
  end

endmodule

`default_nettype wire

//--- rtl/maxpool_unit.sv
`timescale 1ns/10ps
`default_nettype none

module maxpool_unit #(
  parameter int MAX_N = 512
)(
  input  logic                       clk
  ,input  logic                       rst_n
  ,input  logic                       bypass    // Pass all four pixels through
  ,pix_stream_if.snk                  in
  ,output logic                       out_valid
  ,output sta_pkg::pix_t              out_data
  ,output logic [$clog2(MAX_N+1)-1:0] out_row
  ,output logic [$clog2(MAX_N+1)-1:0] out_col
);

  import sta_pkg::*;

  localparam int         CW   = $clog2(MAX_N+1);
  localparam logic [1:0] LAST = 2'(SA_N*SA_N-1);  // Fourth beat of the window

  pix_t          run_max;   // Max so far in the window
  pix_t          cand;      // Max including the current beat
  logic [1:0]    cnt;       // Beats seen in the window
  logic [CW-1:0] base_row;  // First beat coordinates
  logic [CW-1:0] base_col;

  // First beat of a window restarts the max
  assign cand = ((cnt == '0) || (in.data > run_max)) ? in.data : run_max;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      cnt       <= '0;
    end else begin
      out_valid <= in.valid && (bypass || (cnt == LAST));
      if (in.valid && !bypass) begin
        cnt <= (cnt == LAST) ? 2'd0 : cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid) begin
      run_max <= cand;
      if (cnt == '0) begin
        base_row <= in.row;
        base_col <= in.col;
      end
      if (bypass) begin
        out_data <= in.data;
        out_row  <= in.row;
        out_col  <= in.col;
      end else if (cnt == LAST) begin
        out_data <= cand;
        out_row  <= base_row >> 1;  // Pooled map is half size
        out_col  <= base_col >> 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/sta_top.sv
`timescale 1ns/10ps
`default_nettype none

module sta_top #(
  parameter int MAX_N = 512   // Largest output map coordinate
)(
  input  logic                       clk
  ,input  logic                       rst_n
  ,input  logic                       tile_req
  ,input  sta_pkg::klen_t             k_len        // Reduction steps
  ,input  logic [$clog2(MAX_N+1)-1:0] pos_row      // Tile origin in the output map
  ,input  logic [$clog2(MAX_N+1)-1:0] pos_col
  ,input  sta_pkg::scale_t            scale
  ,input  sta_pkg::shift_t            shift
  ,input  logic                       bypass_pool
  ,input  sta_pkg::vec_t              a_vec        // A column for this step
  ,input  sta_pkg::vec_t              b_vec        // B row for this step
  ,output logic                       tile_ack
  ,output logic                       idle
  ,output logic                       feed_ready
  ,output logic                       out_valid
  ,output sta_pkg::pix_t              out_data
  ,output logic [$clog2(MAX_N+1)-1:0] out_row
  ,output logic [$clog2(MAX_N+1)-1:0] out_col
);

  import sta_pkg::*;

  localparam int CW = $clog2(MAX_N+1);

  // Tile settings, held for the whole tile
  logic [CW-1:0] pos_row_q;
  logic [CW-1:0] pos_col_q;
  scale_t        scale_q;
  shift_t        shift_q;
  logic          bypass_q;

  logic  clear;
  logic  capture;
  logic  timer_load;
  logic  timer_expired;
  klen_t timer_count;
  logic  read_start;
  logic  read_done;
  acc_t  acc [SA_N][SA_N];

  pix_stream_if #(.MAX_N(MAX_N), .T(acc_t)) acc_stream ();  // Reader to requantizer
  pix_stream_if #(.MAX_N(MAX_N), .T(pix_t)) pix_stream ();  // Requantizer to pool

  always_ff @(posedge clk) begin
    if (capture) begin
      pos_row_q <= pos_row;
      pos_col_q <= pos_col;
      scale_q   <= scale;
      shift_q   <= shift;
      bypass_q  <= bypass_pool;
    end
  end

  tile_fsm u_fsm (
    .clk            (clk)
    ,.rst_n         (rst_n)
    ,.tile_req      (tile_req)
    ,.k_len         (k_len)          // Taken by the timer on edge 0
    ,.timer_expired (timer_expired)
    ,.read_done     (read_done)
    ,.tile_ack      (tile_ack)
    ,.idle          (idle)
    ,.feed_ready    (feed_ready)
    ,.clear         (clear)
    ,.timer_load    (timer_load)
    ,.timer_count   (timer_count)
    ,.read_start    (read_start)
    ,.capture       (capture)
  );

  cycle_timer u_timer (
    .clk      (clk)
    ,.rst_n   (rst_n)
    ,.load    (timer_load)
    ,.count   (timer_count)
    ,.expired (timer_expired)
  );

  systolic_array u_array (
    .clk    (clk)
    ,.rst_n (rst_n)
    ,.clear (clear)
    ,.feed  (feed_ready)
    ,.a_vec (a_vec)
    ,.b_vec (b_vec)
    ,.acc   (acc)
  );

  result_reader #(.MAX_N(MAX_N)) u_reader (
    .clk         (clk)
    ,.rst_n      (rst_n)
    ,.read_start (read_start)
    ,.acc        (acc)
    ,.pos_row    (pos_row_q)
    ,.pos_col    (pos_col_q)
    ,.read_done  (read_done)
    ,.out        (acc_stream.src)
  );

  requantizer u_requant (
    .clk    (clk)
    ,.rst_n (rst_n)
    ,.scale (scale_q)
    ,.shift (shift_q)
    ,.in    (acc_stream.snk)
    ,.out   (pix_stream.src)
  );

  maxpool_unit #(.MAX_N(MAX_N)) u_pool (
    .clk        (clk)
    ,.rst_n     (rst_n)
    ,.bypass    (bypass_q)
    ,.in        (pix_stream.snk)
    ,.out_valid (out_valid)
    ,.out_data  (out_data)
    ,.out_row   (out_row)
    ,.out_col   (out_col)
  );

endmodule

`default_nettype wire

//--- sim/sta_checker.sv
`timescale 1ns/10ps
`default_nettype none

module sta_checker (
  input logic clk
  ,input logic rst_n
  ,input logic tile_req
  ,input logic tile_ack
  ,input logic feed_ready
  ,input logic out_valid
);

  int assert_fails = 0;  // Read by the testbench at end of run

  // Four-phase: ack holds while the host still requests
  ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
    tile_ack && tile_req |=> tile_ack)
    else begin $error("tile_ack fell while tile_req was high"); assert_fails++; end

  // Ack drops on the edge after req is seen low
  ack_drops: assert property (@(posedge clk) disable iff (!rst_n)
    tile_ack && !tile_req |=> !tile_ack)
    else begin $error("tile_ack stayed high after tile_req fell"); assert_fails++; end

  // Feed and done phases never overlap
  no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(feed_ready && tile_ack))
    else begin $error("feed_ready and tile_ack high together"); assert_fails++; end

  // Synchronous reset clears the handshake and output
  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> (!out_valid && !feed_ready && !tile_ack))
    else begin $error("outputs not low in the cycle after reset"); assert_fails++; end

endmodule

bind sta_top sta_checker u_checker (
  .clk         (clk)
  ,.rst_n      (rst_n)
  ,.tile_req   (tile_req)
  ,.tile_ack   (tile_ack)
  ,.feed_ready (feed_ready)
  ,.out_valid  (out_valid)
);

`default_nettype wire

//--- sim/tb_sta_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sta_top;

  import sta_pkg::*;

  localparam int MAX_N     = 512;
  localparam int CW        = $clog2(MAX_N+1);
  localparam int KMAX      = 16;   // Longest random reduction
  localparam int NUM_RAND  = 8;
  localparam int NUM_POOL  = 4;
  localparam int NUM_B2B   = 3;
  localparam int NUM_TILES = 1 + NUM_RAND + NUM_POOL + 1 + NUM_B2B;
  localparam int WATCHDOG_CYCLES = NUM_TILES * (KMAX + 20) + 200;  // Per-tile bound plus margin

  logic          clk;
  logic          rst_n;
  logic          tile_req;
  klen_t         k_len;
  logic [CW-1:0] pos_row;
  logic [CW-1:0] pos_col;
  scale_t        scale;
  shift_t        shift;
  logic          bypass_pool;
  vec_t          a_vec;
  vec_t          b_vec;
  logic          tile_ack;
  logic          idle;
  logic          feed_ready;
  logic          out_valid;
  pix_t          out_data;
  logic [CW-1:0] out_row;
  logic [CW-1:0] out_col;

  int     a_mat [SA_N][KMAX];  // A[i][k] is lane i of step k
  int     b_mat [KMAX][SA_N];  // B[k][j] is lane j of step k
  int     exp_data [$];        // Expected output beats in order
  int     exp_row [$];
  int     exp_col [$];
  integer seed;
  string  cur_test;
  int     test_errs;
  int     pass_cnt;
  int     fail_cnt;

  sta_top #(.MAX_N(MAX_N)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Scale into 64 bits, floor shift, clamp to int8
  function automatic int requant(input int sum, input int sc, input int sh);
    longint p;
    p = longint'(sum) * longint'(sc);
    p = p >>> sh;
    if (p > 127) return 127;
    if (p < -128) return -128;
    return int'(p);
  endfunction

  // Matrix product, requantize, then pass four pixels or pool to one
  function automatic void ref_tile(input int k, input int prow, input int pcol,
                                   input int sc, input int sh, input bit byp);
    int c;
    int mx;
    int q [SA_N][SA_N];
    for (int i = 0; i < SA_N; i++) begin
      for (int j = 0; j < SA_N; j++) begin
        c = 0;
        for (int s = 0; s < k; s++) c += a_mat[i][s] * b_mat[s][j];
        q[i][j] = requant(c, sc, sh);
      end
    end
    if (byp) begin
      for (int i = 0; i < SA_N; i++) begin
        for (int j = 0; j < SA_N; j++) begin
          exp_data.push_back(q[i][j]);  // Row-major order
          exp_row.push_back(prow + i);
          exp_col.push_back(pcol + j);
        end
      end
    end else begin
      mx = q[0][0];
      for (int i = 0; i < SA_N; i++)
        for (int j = 0; j < SA_N; j++)
          if (q[i][j] > mx) mx = q[i][j];
      exp_data.push_back(mx);
      exp_row.push_back(prow / 2);  // Pooled map is half size
      exp_col.push_back(pcol / 2);
    end
  endfunction

  task automatic fill_random(input int k);
    for (int s = 0; s < k; s++) begin
      for (int i = 0; i < SA_N; i++) a_mat[i][s] = rand_range(-128, 127);
      for (int j = 0; j < SA_N; j++) b_mat[s][j] = rand_range(-128, 127);
    end
  endtask

  task automatic drive_step(input int s, input int k);
    for (int i = 0; i < SA_N; i++) begin
      if (s < k) begin
        a_vec[i] = pix_t'(a_mat[i][s]);
        b_vec[i] = pix_t'(b_mat[s][i]);
      end else begin
        a_vec[i] = '0;  // Past the last step
        b_vec[i] = '0;
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Runs one tile through the four-phase handshake from 1 ns after an edge
  task automatic run_tile(input int k, input int prow, input int pcol,
                          input int sc, input int sh, input bit byp);
    int   consumed;
    int   waited;
    logic fr;
    logic got_ack;
    logic idle_seen;
    ref_tile(k, prow, pcol, sc, sh, byp);
    k_len       = klen_t'(k);
    pos_row     = CW'(prow);
    pos_col     = CW'(pcol);
    scale       = scale_t'(sc);
    shift       = shift_t'(sh);
    bypass_pool = byp;
    tile_req    = 1'b1;
    drive_step(0, k);  // Element 0 goes with the request
    consumed  = 0;
    waited    = 0;
    got_ack   = 1'b0;
    idle_seen = 1'b0;
    while (!got_ack && waited < k + 20) begin
      fr = feed_ready;   // High now means the coming edge consumes
      @(posedge clk);
      #1;
      waited++;
      if (idle) idle_seen = 1'b1;  // FSM leaves IDLE on edge 0
      if (fr) begin
        consumed++;
        drive_step(consumed, k);
      end
      if (tile_ack) got_ack = 1'b1;
    end
    assert (got_ack) else begin
      $display("tile_ack did not rise within %0d cycles in test %s", k + 20, cur_test);
      test_errs++;
    end
    assert (!idle_seen) else begin
      $display("idle was high while the tile was running in test %s", cur_test);
      test_errs++;
    end
    assert (consumed == k) else begin
      $display("[FAIL] %s feed edges expected %0d actual %0d", cur_test, k, consumed);
      test_errs++;
    end
    tile_req = 1'b0;
    waited   = 0;
    while (tile_ack && waited < 4) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (!tile_ack && idle) else begin
      $display("tile_ack did not fall after tile_req dropped in test %s", cur_test);
      test_errs++;
    end
    assert (exp_data.size() == 0) else begin
      $display("%0d expected output beats never appeared in test %s", exp_data.size(), cur_test);
      test_errs++;
    end
    exp_data.delete();
    exp_row.delete();
    exp_col.delete();
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %-14s ok", cur_test);
    end else begin
      fail_cnt++;
      $display("test %-14s %0d errors", cur_test, test_errs);
    end
  endtask

  // Output beats compared mid-cycle against the expected queue
  always @(negedge clk) begin : monitor
    int ed;
    int er;
    int ec;
    if (rst_n && out_valid) begin
      assert (exp_data.size() > 0) else begin
        $display("Unexpected output beat at (%0d,%0d) in test %s", out_row, out_col, cur_test);
        test_errs++;
      end
      if (exp_data.size() > 0) begin
        ed = exp_data.pop_front();
        er = exp_row.pop_front();
        ec = exp_col.pop_front();
        assert (int'(out_data) == ed && int'(out_row) == er && int'(out_col) == ec) else begin
          $display("[FAIL] %s expected %0d at (%0d,%0d) actual %0d at (%0d,%0d)",
                   cur_test, ed, er, ec, out_data, out_row, out_col);
          test_errs++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    int k;
    seed        = 32'he48a25cf;
    rst_n       = 1'b0;
    tile_req    = 1'b0;
    k_len       = klen_t'(1);
    pos_row     = '0;
    pos_col     = '0;
    scale       = '0;
    shift       = '0;
    bypass_pool = 1'b1;
    a_vec       = '0;
    b_vec       = '0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    begin_test("init");
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    begin_test("reset_state");
    assert (idle && !tile_ack && !feed_ready && !out_valid) else begin
      $display("Outputs not at reset values before the first request");
      test_errs++;
    end
    end_test();

    begin_test("small_bypass");
    a_mat[0][0] = 2;
    a_mat[1][0] = 3;
    b_mat[0][0] = 4;
    b_mat[0][1] = 5;
    run_tile(1, 10, 20, 1, 0, 1'b1);  // Plain products 8, 10, 12, 15
    end_test();

    begin_test("random_bypass");
    for (int t = 0; t < NUM_RAND; t++) begin
      k = rand_range(1, KMAX);
      fill_random(k);
      run_tile(k, rand_range(0, 500), rand_range(0, 500), rand_range(-300, 300),
               rand_range(0, 12), 1'b1);
      idle_cycles(2);
    end
    end_test();

    begin_test("pooling");
    for (int t = 0; t < NUM_POOL; t++) begin
      k = rand_range(1, KMAX);
      fill_random(k);
      run_tile(k, rand_range(0, 500), rand_range(0, 500), rand_range(-300, 300),
               rand_range(0, 12), 1'b0);
      idle_cycles(2);
    end
    end_test();

    begin_test("saturation");
    a_mat[0][0] = 100;
    a_mat[1][0] = -100;
    b_mat[0][0] = 50;
    b_mat[0][1] = -50;
    run_tile(1, 4, 6, 32767, 0, 1'b1);  // Sums of +-5000 clamp both ways
    end_test();

    begin_test("back_to_back");
    for (int t = 0; t < NUM_B2B; t++) begin
      k = rand_range(1, KMAX);
      fill_random(k);
      run_tile(k, rand_range(0, 500), rand_range(0, 500), rand_range(-300, 300),
               rand_range(0, 12), (t % 2) == 0);  // No gap between tiles
    end
    end_test();

    idle_cycles(4);
    if (DUT.u_checker.assert_fails != 0)
      $display("Bound assertions failed %0d times", DUT.u_checker.assert_fails);
    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && DUT.u_checker.assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/sta_pkg.sv
rtl/pix_stream_if.sv
rtl/systolic_array.sv
rtl/cycle_timer.sv
rtl/tile_fsm.sv
rtl/result_reader.sv
rtl/requantizer.sv
rtl/maxpool_unit.sv
rtl/sta_top.sv
sim/sta_checker.sv
sim/tb_sta_top.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; exit status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_sta_top -f flist.f &&
./obj_dir/Vtb_sta_top +verilator+error+limit+100 | tee /dev/stderr |
  grep -q "Simulation completed successfully" &&
echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
